// File: design/exec_defs.svh
// Width and constant macros for the execute stage, pulled in by the packages and RTL
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

// Architectural register width
`define XLEN 64

// Word size used by the W-form instructions
`define WORD_W 32

`define REGNO_W 5

// Shift amounts for 64-bit and W forms
`define SHAMT_W 6
`define SHAMT_W_WORD 5

// Bytes per instruction, used to recover the pc from pcplus1
`define PC_STEP 4

`endif

// File: design/rv_isa_pkg.sv
// Architectural value types and the execute op encoding shared by the stage and its testbench
`include "exec_defs.svh"

package rv_isa_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`XLEN-1:0] addr_t;
    typedef logic [`REGNO_W-1:0] regno_t;

    // OP_NOP must stay at encoding 0 so a cleared register reads as a bubble
    typedef enum logic [5:0]
    {
        OP_NOP, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LOAD, OP_STORE,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW
    } exec_op_t;

endpackage

// File: design/exec_pipe_pkg.sv
// Pipeline control types for operand forwarding and the load-use stall
package exec_pipe_pkg;

    // Where a source operand is taken from
    typedef enum logic [1:0] {FWD_REG, FWD_ALU, FWD_MEM, FWD_WB} fwd_src_t;

    typedef enum logic {ST_RUN, ST_LOAD_WAIT} stall_state_t;

endpackage

// File: design/exec_operands_if.sv
// Resolved operand bundle passed from forwarding to the ALU and branch unit
`timescale 1ns/1ns

interface exec_operands_if
    import rv_isa_pkg::*;
(
    input logic clk
);

    exec_op_t op;
    xlen_t value1;
    xlen_t value2;
    xlen_t imm;
    addr_t pcplus1;

    modport source (output op, value1, value2, imm, pcplus1);

    // clk is only there so the consumers can sample for checks
    modport sink (input clk, op, value1, value2, imm, pcplus1);

endinterface

// File: design/operand_forward.sv
// Resolves rs1 and rs2 from the later pipeline stages and flags a load-use hazard
`timescale 1ns/1ns

module operand_forward
    import rv_isa_pkg::*;
    import exec_pipe_pkg::*;
(
    input regno_t rs1_regno,
    input regno_t rs2_regno,
    input xlen_t rs1_value,
    input xlen_t rs2_value,
    input exec_op_t op,
    input xlen_t imm_value,
    input addr_t pcplus1,
    input regno_t alu_rd_regno,
    input regno_t mm_rd_regno,
    input regno_t wb_rd_regno,
    input xlen_t alu_result_fwd,
    input xlen_t mm_mdata,
    input xlen_t mm_alu_result,
    input xlen_t wb_data,
    input logic alu_mm_load,
    input logic mm_mm_load,
    input logic load_wait,
    output logic load_use,
    exec_operands_if.source ops
);

    fwd_src_t src1;
    fwd_src_t src2;

    // Youngest producer wins, x0 is never forwarded
    function automatic fwd_src_t fwd_source(input regno_t rs);
        if (rs == '0)
            return FWD_REG;
        else if (rs == alu_rd_regno)
            return FWD_ALU;
        else if (rs == mm_rd_regno)
            return FWD_MEM;
        else if (rs == wb_rd_regno)
            return FWD_WB;
        return FWD_REG;
    endfunction

    function automatic xlen_t fwd_value(input fwd_src_t src, input xlen_t reg_value);
        case (src)
            // A load one stage ahead only has its data on mm_mdata after the stall
            FWD_ALU: return alu_mm_load ? mm_mdata : alu_result_fwd;
            FWD_MEM: return mm_mm_load ? mm_mdata : mm_alu_result;
            FWD_WB: return wb_data;
            default: return reg_value;
        endcase
    endfunction

    always_comb
    begin
        src1 = fwd_source(rs1_regno);
        src2 = fwd_source(rs2_regno);
        ops.value1 = fwd_value(src1, rs1_value);
        ops.value2 = fwd_value(src2, rs2_value);
        load_use = alu_mm_load && !load_wait && (src1 == FWD_ALU || src2 == FWD_ALU);
    end

    assign ops.op = op;
    assign ops.imm = imm_value;
    assign ops.pcplus1 = pcplus1;

endmodule

// File: design/int_alu.sv
// Integer result and load/store address computation for the execute stage
`timescale 1ns/1ns
`include "exec_defs.svh"

module int_alu
    import rv_isa_pkg::*;
(
    exec_operands_if.sink ops,
    output xlen_t result,
    output logic update_rd,
    output logic mm_load
);

    logic imm_form;
    xlen_t opb;
    logic [`SHAMT_W-1:0] shamt;
    logic [`SHAMT_W_WORD-1:0] shamt_word;
    logic [`WORD_W-1:0] word_a;
    logic [`WORD_W-1:0] word_b;

    function automatic xlen_t sext_word(input logic [`WORD_W-1:0] w);
        return {{(`XLEN-`WORD_W){w[`WORD_W-1]}}, w};
    endfunction

    assign imm_form = ops.op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
                                     OP_SLLI, OP_SRLI, OP_SRAI,
                                     OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW};
    assign opb = imm_form ? ops.imm : ops.value2;
    assign shamt = opb[`SHAMT_W-1:0];
    assign shamt_word = opb[`SHAMT_W_WORD-1:0];
    assign word_a = ops.value1[`WORD_W-1:0];
    assign word_b = opb[`WORD_W-1:0];

    always_comb
    begin
        result = '0;
        update_rd = 1'b1;
        mm_load = 1'b0;
        case (ops.op)
            OP_ADD, OP_ADDI: result = ops.value1 + opb;
            OP_SUB: result = ops.value1 - opb;
            OP_SLL, OP_SLLI: result = ops.value1 << shamt;
            OP_SRL, OP_SRLI: result = ops.value1 >> shamt;
            OP_SRA, OP_SRAI: result = $signed(ops.value1) >>> shamt;
            OP_SLT, OP_SLTI: result = xlen_t'($signed(ops.value1) < $signed(opb));
            OP_SLTU, OP_SLTIU: result = xlen_t'(ops.value1 < opb);
            OP_XOR, OP_XORI: result = ops.value1 ^ opb;
            OP_OR, OP_ORI: result = ops.value1 | opb;
            OP_AND, OP_ANDI: result = ops.value1 & opb;
            OP_ADDW, OP_ADDIW: result = sext_word(word_a + word_b);
            OP_SUBW: result = sext_word(word_a - word_b);
            OP_SLLW, OP_SLLIW: result = sext_word(word_a << shamt_word);
            OP_SRLW, OP_SRLIW: result = sext_word(word_a >> shamt_word);
            OP_SRAW, OP_SRAIW: result = sext_word($signed(word_a) >>> shamt_word);
            OP_LUI: result = ops.imm;
            OP_AUIPC: result = ops.pcplus1 - `PC_STEP + ops.imm;
            // Link address
            OP_JAL, OP_JALR: result = ops.pcplus1;
            OP_LOAD:
            begin
                result = ops.value1 + ops.imm;
                update_rd = 1'b0;
                mm_load = 1'b1;
            end
            OP_STORE:
            begin
                result = ops.value1 + ops.imm;
                update_rd = 1'b0;
            end
            default: update_rd = 1'b0;
        endcase
    end

    // Memory stage must never see a load that also writes rd from the ALU
    no_load_and_write: assert property (@(posedge ops.clk) !(update_rd && mm_load));

endmodule

// File: design/branch_unit.sv
// Branch decision and next-pc target for conditional branches, jal and jalr
`timescale 1ns/1ns
`include "exec_defs.svh"

module branch_unit
    import rv_isa_pkg::*;
(
    exec_operands_if.sink ops,
    output logic taken,
    output addr_t target
);

    addr_t pc_rel_target;
    xlen_t jalr_sum;

    always_comb
    begin
        case (ops.op)
            OP_BEQ: taken = ops.value1 == ops.value2;
            OP_BNE: taken = ops.value1 != ops.value2;
            OP_BLT: taken = $signed(ops.value1) < $signed(ops.value2);
            OP_BGE: taken = $signed(ops.value1) >= $signed(ops.value2);
            OP_BLTU: taken = ops.value1 < ops.value2;
            OP_BGEU: taken = ops.value1 >= ops.value2;
            OP_JAL, OP_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Offsets are relative to the branch's own pc
    assign pc_rel_target = ops.pcplus1 - `PC_STEP + ops.imm;
    assign jalr_sum = ops.value1 + ops.imm;

    assign target = !taken ? ops.pcplus1 :
                    (ops.op == OP_JALR) ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_rel_target;

endmodule

// File: design/exec_control.sv
// Load-use stall FSM with the ready, capture and bubble decisions of the execute stage
`timescale 1ns/1ns

module exec_control
    import exec_pipe_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic enable,
    input logic load_use,
    input logic branch_taken_in,
    input logic syscall_flush,
    output logic ready,
    output logic load_wait,
    output logic capture,
    output logic bubble
);

    stall_state_t state;
    stall_state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_RUN: if (enable && load_use) state_next = ST_LOAD_WAIT;
            ST_LOAD_WAIT: if (capture || syscall_flush) state_next = ST_RUN;
            default: state_next = ST_RUN;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= ST_RUN;
        else
            state <= state_next;
    end

    // load_use is masked in the wait state, so only the first cycle stalls
    assign ready = ~(enable & load_use);
    assign load_wait = (state == ST_LOAD_WAIT);
    assign capture = enable & ready;
    assign bubble = syscall_flush | (capture & branch_taken_in);

    single_cycle_stall: assert property (@(posedge clk) disable iff (reset) !ready |=> ready);

endmodule

// File: design/ex_mem_register.sv
// EX/MEM pipeline register that captures the stage results or loads a bubble
`timescale 1ns/1ns

module ex_mem_register
    import rv_isa_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic capture,
    input logic bubble,
    input xlen_t result,
    input xlen_t rs2,
    input regno_t rd,
    input exec_op_t op,
    input addr_t target,
    input logic update_rd_in,
    input logic taken_in,
    input logic mm_load_in,
    output xlen_t alu_result,
    output xlen_t rs2_out,
    output regno_t rd_out,
    output exec_op_t op_out,
    output addr_t target_pc,
    output logic update_rd,
    output logic branch_taken,
    output logic mm_load
);

    always_ff @(posedge clk)
    begin
        // Flush has priority over a new capture
        if (reset || bubble)
        begin
            alu_result <= '0;
            rs2_out <= '0;
            rd_out <= '0;
            op_out <= OP_NOP;
            target_pc <= '0;
            update_rd <= 1'b0;
            branch_taken <= 1'b0;
            mm_load <= 1'b0;
        end
        else if (capture)
        begin
            alu_result <= result;
            rs2_out <= rs2;
            rd_out <= rd;
            op_out <= op;
            target_pc <= target;
            update_rd <= update_rd_in;
            branch_taken <= taken_in;
            mm_load <= mm_load_in;
        end
    end

    taken_not_load: assert property (@(posedge clk) disable iff (reset) !(branch_taken && mm_load));

endmodule

// File: design/exec_stage.sv
// Execute stage of the RV64I pipeline, connecting forwarding, ALU, branch unit and EX/MEM register
`timescale 1ns/1ns

module exec_stage
    import rv_isa_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic enable,
    input xlen_t rs1_value,
    input xlen_t rs2_value,
    input xlen_t imm_value,
    input regno_t rd_regno,
    input regno_t rs1_regno,
    input regno_t rs2_regno,
    input exec_op_t op,
    input regno_t alu_rd_regno,
    input regno_t mm_rd_regno,
    input regno_t wb_rd_regno,
    input xlen_t alu_result_fwd,
    input xlen_t mm_mdata,
    input xlen_t mm_alu_result,
    input xlen_t wb_data,
    input addr_t pcplus1,
    input logic branch_taken_in,
    input logic alu_mm_load,
    input logic mm_mm_load,
    input logic syscall_flush,
    output xlen_t alu_result,
    output xlen_t rs2_out,
    output regno_t rd_out,
    output exec_op_t op_out,
    output addr_t target_pc,
    output logic update_rd,
    output logic branch_taken,
    output logic mm_load,
    output logic ready
);

    logic load_use;
    logic load_wait;
    logic capture;
    logic bubble;
    xlen_t ex_result;
    logic ex_update_rd;
    logic ex_mm_load;
    logic ex_taken;
    addr_t ex_target;

    exec_operands_if i_ops (.clk(clk));

    operand_forward i_operand_forward (
        .rs1_regno(rs1_regno), .rs2_regno(rs2_regno),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .op(op), .imm_value(imm_value), .pcplus1(pcplus1),
        .alu_rd_regno(alu_rd_regno), .mm_rd_regno(mm_rd_regno), .wb_rd_regno(wb_rd_regno),
        .alu_result_fwd(alu_result_fwd), .mm_mdata(mm_mdata),
        .mm_alu_result(mm_alu_result), .wb_data(wb_data),
        .alu_mm_load(alu_mm_load), .mm_mm_load(mm_mm_load), .load_wait(load_wait),
        .load_use(load_use), .ops(i_ops.source)
    );

    int_alu i_int_alu (
        .ops(i_ops.sink), .result(ex_result), .update_rd(ex_update_rd), .mm_load(ex_mm_load)
    );

    branch_unit i_branch_unit (.ops(i_ops.sink), .taken(ex_taken), .target(ex_target));

    exec_control i_exec_control (
        .clk(clk), .reset(reset), .enable(enable), .load_use(load_use),
        .branch_taken_in(branch_taken_in), .syscall_flush(syscall_flush),
        .ready(ready), .load_wait(load_wait), .capture(capture), .bubble(bubble)
    );

    ex_mem_register i_ex_mem_register (
        .clk(clk), .reset(reset), .capture(capture), .bubble(bubble),
        .result(ex_result), .rs2(i_ops.value2), .rd(rd_regno), .op(op), .target(ex_target),
        .update_rd_in(ex_update_rd), .taken_in(ex_taken), .mm_load_in(ex_mm_load),
        .alu_result(alu_result), .rs2_out(rs2_out), .rd_out(rd_out), .op_out(op_out),
        .target_pc(target_pc), .update_rd(update_rd), .branch_taken(branch_taken),
        .mm_load(mm_load)
    );

endmodule

// File: tests/tb_clock.sv
// Free-running clock for the execute stage testbench, instantiated once by the testbench top
`timescale 1ns/1ns

module tb_clock
#(
    parameter int PERIOD = 8
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: tests/tb_exec_stage.sv
// Testbench for the execute stage, random stimulus checked against a reference model by assertions
`timescale 1ns/1ns
`include "exec_defs.svh"

module tb_exec_stage
    import rv_isa_pkg::*;
    import exec_pipe_pkg::*;
();

    typedef struct packed {
        xlen_t result;
        xlen_t rs2;
        regno_t rd;
        exec_op_t op;
        addr_t target;
        logic update;
        logic taken;
        logic load;
    } ex_mem_t;

    logic clk;
    logic reset;
    logic enable;
    logic branch_taken_in, alu_mm_load, mm_mm_load, syscall_flush;
    xlen_t rs1_value, rs2_value, imm_value;
    xlen_t alu_result_fwd, mm_mdata, mm_alu_result, wb_data;
    regno_t rd_regno, rs1_regno, rs2_regno;
    regno_t alu_rd_regno, mm_rd_regno, wb_rd_regno;
    exec_op_t op;
    addr_t pcplus1;
    xlen_t alu_result, rs2_out;
    regno_t rd_out;
    exec_op_t op_out;
    addr_t target_pc;
    logic update_rd, branch_taken, mm_load, ready;

    // Reference model state
    xlen_t exp_v1, exp_v2, exp_result;
    addr_t exp_target;
    logic exp_update, exp_load, exp_taken, hazard, exp_ready, exp_capture;
    stall_state_t model_state;
    ex_mem_t model;

    tb_clock #(.PERIOD(8)) i_clock (.clk(clk));

    exec_stage i_exec_stage (.*);

    task automatic report_mismatch(input string what);
        $display("CHECK FAILED at %0t ns: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "stopped after a timeout");
    endtask

    // Youngest stage first, x0 always reads the register file
    function automatic xlen_t resolve_operand(input regno_t rs, input xlen_t reg_value);
        if (rs == 0)
            return reg_value;
        if (rs == alu_rd_regno)
            return alu_mm_load ? mm_mdata : alu_result_fwd;
        if (rs == mm_rd_regno)
            return mm_mm_load ? mm_mdata : mm_alu_result;
        if (rs == wb_rd_regno)
            return wb_data;
        return reg_value;
    endfunction

    function automatic xlen_t compute_result(input exec_op_t o, input xlen_t a, input xlen_t b,
                                             input xlen_t imm, input addr_t pc1);
        xlen_t y;
        logic [`WORD_W-1:0] w;
        y = (o inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI,
                       OP_SRAI, OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW}) ? imm : b;
        w = '0;
        case (o)
            OP_ADD, OP_ADDI: return a + y;
            OP_SUB: return a - y;
            OP_SLL, OP_SLLI: return a << y[`SHAMT_W-1:0];
            OP_SRL, OP_SRLI: return a >> y[`SHAMT_W-1:0];
            OP_SRA, OP_SRAI: return $signed(a) >>> y[`SHAMT_W-1:0];
            OP_SLT, OP_SLTI: return xlen_t'($signed(a) < $signed(y));
            OP_SLTU, OP_SLTIU: return xlen_t'(a < y);
            OP_XOR, OP_XORI: return a ^ y;
            OP_OR, OP_ORI: return a | y;
            OP_AND, OP_ANDI: return a & y;
            OP_ADDW, OP_ADDIW: w = a[`WORD_W-1:0] + y[`WORD_W-1:0];
            OP_SUBW: w = a[`WORD_W-1:0] - y[`WORD_W-1:0];
            OP_SLLW, OP_SLLIW: w = a[`WORD_W-1:0] << y[`SHAMT_W_WORD-1:0];
            OP_SRLW, OP_SRLIW: w = a[`WORD_W-1:0] >> y[`SHAMT_W_WORD-1:0];
            OP_SRAW, OP_SRAIW: w = $signed(a[`WORD_W-1:0]) >>> y[`SHAMT_W_WORD-1:0];
            OP_LUI: return imm;
            OP_AUIPC: return pc1 - `PC_STEP + imm;
            OP_JAL, OP_JALR: return pc1;
            OP_LOAD, OP_STORE: return a + imm;
            default: return '0;
        endcase
        return {{(`XLEN-`WORD_W){w[`WORD_W-1]}}, w};
    endfunction

    function automatic logic branch_decision(input exec_op_t o, input xlen_t a, input xlen_t b);
        case (o)
            OP_BEQ: return a == b;
            OP_BNE: return a != b;
            OP_BLT: return $signed(a) < $signed(b);
            OP_BGE: return !($signed(a) < $signed(b));
            OP_BLTU: return a < b;
            OP_BGEU: return !(a < b);
            OP_JAL, OP_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    always_comb
    begin
        exp_v1 = resolve_operand(rs1_regno, rs1_value);
        exp_v2 = resolve_operand(rs2_regno, rs2_value);
        exp_result = compute_result(op, exp_v1, exp_v2, imm_value, pcplus1);
        exp_load = (op == OP_LOAD);
        exp_update = !(op inside {OP_NOP, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                                  OP_LOAD, OP_STORE});
        exp_taken = branch_decision(op, exp_v1, exp_v2);
        if (!exp_taken)
            exp_target = pcplus1;
        else if (op == OP_JALR)
            exp_target = (exp_v1 + imm_value) & ~xlen_t'(1);
        else
            exp_target = pcplus1 - `PC_STEP + imm_value;
        hazard = alu_mm_load && model_state == ST_RUN && alu_rd_regno != 0
                 && (rs1_regno == alu_rd_regno || rs2_regno == alu_rd_regno);
        exp_ready = !(enable && hazard);
        exp_capture = enable && exp_ready;
    end

    always @(posedge clk)
    begin
        if (reset)
            model_state <= ST_RUN;
        else if (model_state == ST_RUN && enable && hazard)
            model_state <= ST_LOAD_WAIT;
        else if (model_state == ST_LOAD_WAIT && (exp_capture || syscall_flush))
            model_state <= ST_RUN;
        // A cleared entry is a bubble since OP_NOP encodes as zero
        if (reset || syscall_flush || (exp_capture && branch_taken_in))
            model <= '0;
        else if (exp_capture)
            model <= '{exp_result, exp_v2, rd_regno, op, exp_target,
                       exp_update, exp_taken, exp_load};
    end

    ready_matches: assert property (@(posedge clk) disable iff (reset) ready == exp_ready)
        else report_mismatch("ready differs from the load-use model");
    result_matches: assert property (@(posedge clk) disable iff (reset)
        alu_result == model.result && rs2_out == model.rs2 && rd_out == model.rd)
        else report_mismatch("alu_result, rs2_out or rd_out differs from the model");
    control_matches: assert property (@(posedge clk) disable iff (reset)
        op_out == model.op && update_rd == model.update && mm_load == model.load)
        else report_mismatch("op_out, update_rd or mm_load differs from the model");
    branch_matches: assert property (@(posedge clk) disable iff (reset)
        branch_taken == model.taken && target_pc == model.target)
        else report_mismatch("branch_taken or target_pc differs from the model");

    // Small regno pool makes stage matches and their combinations frequent
    task automatic drive_random(input bit forward_mix, input bit flush_mix);
        rs1_value = {$urandom, $urandom};
        rs2_value = ($urandom_range(3) == 0) ? rs1_value : {$urandom, $urandom};
        imm_value = {$urandom, $urandom};
        op = exec_op_t'($urandom_range(int'(OP_SRAIW), int'(OP_LUI)));
        pcplus1 = {$urandom, $urandom} & ~xlen_t'(3);
        rd_regno = regno_t'($urandom_range(31));
        rs1_regno = regno_t'(forward_mix ? $urandom_range(3) : $urandom_range(31, 1));
        rs2_regno = regno_t'(forward_mix ? $urandom_range(3) : $urandom_range(31, 1));
        alu_rd_regno = regno_t'(forward_mix ? $urandom_range(3) : 0);
        mm_rd_regno = regno_t'(forward_mix ? $urandom_range(3) : 0);
        wb_rd_regno = regno_t'(forward_mix ? $urandom_range(3) : 0);
        alu_result_fwd = {$urandom, $urandom};
        mm_mdata = {$urandom, $urandom};
        mm_alu_result = {$urandom, $urandom};
        wb_data = {$urandom, $urandom};
        alu_mm_load = 1'($urandom_range(1));
        mm_mm_load = 1'($urandom_range(1));
        branch_taken_in = flush_mix && $urandom_range(3) == 0;
        syscall_flush = flush_mix && $urandom_range(7) == 0;
    endtask

    // Returns on the falling edge after the instruction was taken
    task automatic wait_capture();
        int cycles;
        cycles = 0;
        #1;
        while (!ready)
        begin
            cycles++;
            if (cycles > 3)
                report_timeout("ready stayed low while an instruction waited");
            @(negedge clk);
            #1;
        end
        @(negedge clk);
    endtask

    initial
    begin
        void'($urandom(32'hd334_421e));
        reset = 1'b1;
        enable = 1'b0;
        drive_random(1'b0, 1'b0);
        repeat (5) @(negedge clk);
        reset = 1'b0;
        #1;
        after_reset: assert (ready && !update_rd && !branch_taken && !mm_load)
            else report_mismatch("outputs are not idle after reset");
        @(negedge clk);
        enable = 1'b1;
        repeat (300)
        begin
            drive_random(1'b0, 1'b0);
            wait_capture();
        end
        repeat (400)
        begin
            drive_random(1'b1, 1'b0);
            wait_capture();
        end
        repeat (200)
        begin
            drive_random(1'b1, 1'b1);
            wait_capture();
        end
        // Flush while the stage is idle
        enable = 1'b0;
        syscall_flush = 1'b1;
        @(negedge clk);
        syscall_flush = 1'b0;
        repeat (2) @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/rv_isa_pkg.sv
design/exec_pipe_pkg.sv
design/exec_operands_if.sv
design/operand_forward.sv
design/int_alu.sv
design/branch_unit.sv
design/exec_control.sv
design/ex_mem_register.sv
design/exec_stage.sv
tests/tb_clock.sv
tests/tb_exec_stage.sv

// File: Makefile
TOP = tb_exec_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
